/* verilog/pcm_dec_pkg.sv */
//--------------------------------------------------
// PCM bit decoder shared definitions
// Config word, symbol pair, modes and register map
//--------------------------------------------------
package pcm_dec_pkg;

  //--------------------------------------------------
  // Register map
  //--------------------------------------------------

  // Byte offsets on the APB port
  localparam int unsigned REG_CFG   = 32'h0;
  localparam int unsigned REG_COUNT = 32'h4;

  //--------------------------------------------------
  // Mode encodings
  //--------------------------------------------------

  // Differential code, value 3 is decoded as NRZ-L
  typedef enum logic [1:0] {
    CODE_NRZL = 2'd0,
    CODE_NRZM = 2'd1,
    CODE_NRZS = 2'd2
  } code_mode_e;

  // Derandomizer polynomial
  // Unlisted values fall back to RNRZ15
  typedef enum logic [2:0] {
    DERAND_OFF    = 3'd0,
    DERAND_RNRZ9  = 3'd1,
    DERAND_RNRZ11 = 3'd2,
    DERAND_RNRZ15 = 3'd3,
    DERAND_RNRZ17 = 3'd4,
    DERAND_RNRZ23 = 3'd5
  } derand_mode_e;

  //--------------------------------------------------
  // Packed records
  //--------------------------------------------------

  // CFG register layout, MSB first
  typedef struct packed {
    derand_mode_e derand;   // 7:5
    logic         invert;   // 4
    logic         swap;     // 3
    code_mode_e   code;     // 2:1
    logic         biphase;  // 0
  } pcm_cfg_t;

  // One I/Q bit pair between pipeline stages
  typedef struct packed {
    logic i;
    logic q;
    logic vld;
  } sym_t;

endpackage

/* verilog/pcm_dec_regs.sv */
//--------------------------------------------------
// PCM decoder APB register block
// Config storage, bit count readback, clear strobe
//--------------------------------------------------
module pcm_dec_regs import pcm_dec_pkg::*; #(
  parameter int ADDR_W = 12
) (
  input  logic              clk,
  input  logic              rs,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [ADDR_W-1:0] paddr_i,
  input  logic [31:0]       pwdata_i,
  output logic [31:0]       prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  input  logic [15:0]       bit_count_i,
  output pcm_cfg_t          cfg_o,
  output logic              cfg_clr_o
);

  // Offsets sized to the bus
  localparam logic [ADDR_W-1:0] CFG_ADDR   = ADDR_W'(REG_CFG);
  localparam logic [ADDR_W-1:0] COUNT_ADDR = ADDR_W'(REG_COUNT);

  logic     access;
  logic     hit_cfg;
  logic     hit_count;
  logic     wr_cfg;
  pcm_cfg_t cfg_q;
  logic     clr_q;

  //--------------------------------------------------
  // Address decode
  //--------------------------------------------------

  // Access phase, never stretched
  assign access    = psel_i & penable_i;
  assign hit_cfg   = (paddr_i == CFG_ADDR);
  assign hit_count = (paddr_i == COUNT_ADDR);
  assign wr_cfg    = access & pwrite_i & hit_cfg;

  assign pready_o  = access;
  // Anything outside the two offsets is an error
  assign pslverr_o = access & ~(hit_cfg | hit_count);

  //--------------------------------------------------
  // Config register and clear strobe
  //--------------------------------------------------

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      cfg_q <= '0;
      clr_q <= 1'b0;
    end else begin
      // One-cycle pulse lines up with the new config
      clr_q <= wr_cfg;
      if (wr_cfg) begin
        cfg_q <= pcm_cfg_t'(pwdata_i[7:0]);
      end
    end
  end

  assign cfg_o     = cfg_q;
  assign cfg_clr_o = clr_q;

  // Read mux, zero outside the access phase
  always_comb begin
    prdata_o = 32'h0;
    if (access && hit_cfg) begin
      prdata_o = {24'h0, cfg_q};
    end else if (access && hit_count) begin
      prdata_o = {16'h0, bit_count_i};
    end
  end

endmodule

/* verilog/biphase_to_nrz.sv */
//--------------------------------------------------
// Biphase to NRZ input stage
// Pairs half-symbols or passes NRZ symbols through
//--------------------------------------------------
module biphase_to_nrz import pcm_dec_pkg::*; (
  input  logic clk,
  input  logic rs,
  input  logic clr_i,
  input  logic biphase_i,
  input  logic symb_en_i,
  input  logic symb_i_i,
  input  logic symb_q_i,
  output sym_t sym_o
);

  // High while waiting for the second half
  logic phase_q;
  logic vld_q;
  // First-half bits of both lanes
  logic half_i_q;
  logic half_q_q;
  logic bit_i_q;
  logic bit_q_q;
  logic take_bit;

  // Bit completes on every NRZ symbol or on the second half
  assign take_bit = symb_en_i & (~biphase_i | phase_q);

  //--------------------------------------------------
  // Phase flag and valid
  //--------------------------------------------------

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      phase_q <= 1'b0;
      vld_q   <= 1'b0;
    end else if (clr_i) begin
      phase_q <= 1'b0;
      vld_q   <= 1'b0;
    end else begin
      vld_q <= take_bit;
      // Toggle per half-symbol, stays low in NRZ mode
      if (symb_en_i && biphase_i) begin
        phase_q <= ~phase_q;
      end
    end
  end

  //--------------------------------------------------
  // Payload
  //--------------------------------------------------

  always_ff @(posedge clk) begin
    // Hold the first half of a pair
    if (symb_en_i && !phase_q) begin
      half_i_q <= symb_i_i;
      half_q_q <= symb_q_i;
    end
    // 1-0 gives 1 and 0-1 gives 0, so the first half is the bit
    if (take_bit) begin
      bit_i_q <= biphase_i ? half_i_q : symb_i_i;
      bit_q_q <= biphase_i ? half_q_q : symb_q_i;
    end
  end

  assign sym_o = '{i: bit_i_q, q: bit_q_q, vld: vld_q};

endmodule

/* verilog/mark_space_decode.sv */
//--------------------------------------------------
// Mark/space differential decoder, one lane
//--------------------------------------------------
module mark_space_decode import pcm_dec_pkg::*; (
  input  logic       clk,
  input  logic       rs,
  input  logic       clr_i,
  input  code_mode_e mode_i,
  input  logic       bit_i,
  input  logic       vld_i,
  output logic       bit_o,
  output logic       vld_o
);

  // Last raw bit of this lane
  logic prev_q;
  logic vld_q;
  logic bit_q;
  logic dec;

  // Transition detect for M, inverted for S
  always_comb begin
    case (mode_i)
      CODE_NRZM: dec = bit_i ^ prev_q;
      CODE_NRZS: dec = ~(bit_i ^ prev_q);
      default:   dec = bit_i;
    endcase
  end

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      prev_q <= 1'b0;
      vld_q  <= 1'b0;
    end else if (clr_i) begin
      prev_q <= 1'b0;
      vld_q  <= 1'b0;
    end else begin
      vld_q <= vld_i;
      if (vld_i) begin
        prev_q <= bit_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (vld_i) begin
      bit_q <= dec;
    end
  end

  assign bit_o = bit_q;
  assign vld_o = vld_q;

endmodule

/* verilog/rnrz_derandomizer.sv */
//--------------------------------------------------
// Self-synchronizing RNRZ descrambler, two lanes
//--------------------------------------------------
module rnrz_derandomizer import pcm_dec_pkg::*; (
  input  logic         clk,
  input  logic         rs,
  input  logic         clr_i,
  input  derand_mode_e mode_i,
  input  sym_t         sym_i,
  output sym_t         sym_o
);

  // Received-bit history, newest in bit 0
  logic [22:0] hist_i_q;
  logic [22:0] hist_q_q;
  logic        vld_q;
  logic        out_i_q;
  logic        out_q_q;
  logic        key_i;
  logic        key_q;

  //--------------------------------------------------
  // Tap selection
  //--------------------------------------------------

  // Polynomial taps are 1-based, history is 0-based
  function automatic logic tap_xor(input logic [22:0] hist, input derand_mode_e mode);
    case (mode)
      DERAND_RNRZ9:  tap_xor = hist[8] ^ hist[4];
      DERAND_RNRZ11: tap_xor = hist[10] ^ hist[8];
      DERAND_RNRZ17: tap_xor = hist[16] ^ hist[13];
      DERAND_RNRZ23: tap_xor = hist[22] ^ hist[17];
      DERAND_OFF:    tap_xor = 1'b0;
      // RNRZ15 and the unused codes
      default:       tap_xor = hist[14] ^ hist[13];
    endcase
  endfunction

  // Zero key when off, so the bit passes through
  assign key_i = tap_xor(hist_i_q, mode_i);
  assign key_q = tap_xor(hist_q_q, mode_i);

  //--------------------------------------------------
  // History and valid
  //--------------------------------------------------

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      hist_i_q <= '0;
      hist_q_q <= '0;
      vld_q    <= 1'b0;
    end else if (clr_i) begin
      hist_i_q <= '0;
      hist_q_q <= '0;
      vld_q    <= 1'b0;
    end else begin
      vld_q <= sym_i.vld;
      // Shifts even when off, keeps sync on a mode change
      if (sym_i.vld) begin
        hist_i_q <= {hist_i_q[21:0], sym_i.i};
        hist_q_q <= {hist_q_q[21:0], sym_i.q};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sym_i.vld) begin
      out_i_q <= sym_i.i ^ key_i;
      out_q_q <= sym_i.q ^ key_q;
    end
  end

  assign sym_o = '{i: out_i_q, q: out_q_q, vld: vld_q};

endmodule

/* verilog/pcm_out_format.sv */
//--------------------------------------------------
// Output formatter with swap, invert, bit count
//--------------------------------------------------
module pcm_out_format import pcm_dec_pkg::*; (
  input  logic        clk,
  input  logic        rs,
  input  logic        clr_i,
  input  logic        swap_i,
  input  logic        invert_i,
  input  sym_t        sym_i,
  output logic        dout_i_o,
  output logic        dout_q_o,
  output logic        bit_vld_o,
  output logic [15:0] bit_count_o
);

  logic        sel_i;
  logic        sel_q;
  logic        dout_i_q;
  logic        dout_q_q;
  logic        vld_q;
  logic [15:0] count_q;

  // Swap first, then complement both lanes
  assign sel_i = (swap_i ? sym_i.q : sym_i.i) ^ invert_i;
  assign sel_q = (swap_i ? sym_i.i : sym_i.q) ^ invert_i;

  //--------------------------------------------------
  // Strobe and bit counter
  //--------------------------------------------------

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      vld_q   <= 1'b0;
      count_q <= 16'h0;
    end else if (clr_i) begin
      vld_q   <= 1'b0;
      count_q <= 16'h0;
    end else begin
      vld_q <= sym_i.vld;
      // Wraps at 16 bits
      if (sym_i.vld) begin
        count_q <= count_q + 16'd1;
      end
    end
  end

  // Output data holds between strobes
  always_ff @(posedge clk) begin
    if (sym_i.vld) begin
      dout_i_q <= sel_i;
      dout_q_q <= sel_q;
    end
  end

  assign dout_i_o    = dout_i_q;
  assign dout_q_o    = dout_q_q;
  assign bit_vld_o   = vld_q;
  assign bit_count_o = count_q;

endmodule

/* verilog/pcm_decoder_top.sv */
//--------------------------------------------------
// PCM bit decoder top level
// APB registers plus four-stage bit pipeline
//--------------------------------------------------
module pcm_decoder_top import pcm_dec_pkg::*; #(
  parameter int ADDR_W = 12
) (
  input  logic              clk,
  input  logic              rs,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [ADDR_W-1:0] paddr_i,
  input  logic [31:0]       pwdata_i,
  output logic [31:0]       prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  input  logic              symb_en_i,
  input  logic              symb_i_i,
  input  logic              symb_q_i,
  output logic              dout_i_o,
  output logic              dout_q_o,
  output logic              bit_vld_o
);

  pcm_cfg_t    cfg;
  logic        cfg_clr;
  logic [15:0] bit_count;
  sym_t        nrz_sym;
  sym_t        dec_sym;
  sym_t        der_sym;
  logic        dec_i;
  logic        dec_q;
  logic        dec_vld_i;
  logic        dec_vld_q;

  pcm_dec_regs #(.ADDR_W(ADDR_W)) u_regs (
    .clk(clk), .rs(rs),
    .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
    .pready_o(pready_o), .pslverr_o(pslverr_o),
    .bit_count_i(bit_count), .cfg_o(cfg), .cfg_clr_o(cfg_clr)
  );

  //--------------------------------------------------
  // Pipeline, one register per stage
  //--------------------------------------------------

  biphase_to_nrz u_bp (
    .clk(clk), .rs(rs), .clr_i(cfg_clr), .biphase_i(cfg.biphase),
    .symb_en_i(symb_en_i), .symb_i_i(symb_i_i), .symb_q_i(symb_q_i),
    .sym_o(nrz_sym)
  );

  // One decoder per lane, same mode
  mark_space_decode u_ms_i (
    .clk(clk), .rs(rs), .clr_i(cfg_clr), .mode_i(cfg.code),
    .bit_i(nrz_sym.i), .vld_i(nrz_sym.vld), .bit_o(dec_i), .vld_o(dec_vld_i)
  );

  mark_space_decode u_ms_q (
    .clk(clk), .rs(rs), .clr_i(cfg_clr), .mode_i(cfg.code),
    .bit_i(nrz_sym.q), .vld_i(nrz_sym.vld), .bit_o(dec_q), .vld_o(dec_vld_q)
  );

  // Lanes run in lockstep, valids always agree
  assign dec_sym = '{i: dec_i, q: dec_q, vld: dec_vld_i & dec_vld_q};

  rnrz_derandomizer u_derand (
    .clk(clk), .rs(rs), .clr_i(cfg_clr), .mode_i(cfg.derand),
    .sym_i(dec_sym), .sym_o(der_sym)
  );

  pcm_out_format u_fmt (
    .clk(clk), .rs(rs), .clr_i(cfg_clr), .swap_i(cfg.swap), .invert_i(cfg.invert),
    .sym_i(der_sym), .dout_i_o(dout_i_o), .dout_q_o(dout_q_o),
    .bit_vld_o(bit_vld_o), .bit_count_o(bit_count)
  );

endmodule

/* verification/pcm_decoder_tb.sv */
//--------------------------------------------------
// PCM bit decoder testbench
// Table-driven cases over APB and the symbol input
//--------------------------------------------------
module pcm_decoder_tb import pcm_dec_pkg::*; ();

  localparam int ADDR_W    = 12;
  localparam int MAX_CASES = 16;
  // Words per line of the cases file
  localparam int FIELDS    = 7;
  localparam int DLY       = 10;

  logic              clk;
  logic              rs;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [ADDR_W-1:0] paddr;
  logic [31:0]       pwdata;
  logic [31:0]       prdata;
  logic              pready;
  logic              pslverr;
  logic              symb_en;
  logic              symb_i;
  logic              symb_q;
  logic              dout_i;
  logic              dout_q;
  logic              bit_vld;

  logic [31:0] case_mem [MAX_CASES*FIELDS];
  int          n_cases;
  bit          cases_loaded;
  int unsigned cyc;
  int          n_got;
  logic [31:0] got_i;
  logic [31:0] got_q;
  // Cycle numbers of symbols that complete a bit
  int unsigned pend_q[$];

  pcm_decoder_top #(.ADDR_W(ADDR_W)) UUT (
    .clk(clk), .rs(rs),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
    .pready_o(pready), .pslverr_o(pslverr),
    .symb_en_i(symb_en), .symb_i_i(symb_i), .symb_q_i(symb_q),
    .dout_i_o(dout_i), .dout_q_o(dout_q), .bit_vld_o(bit_vld)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  //--------------------------------------------------
  // Failure handling
  //--------------------------------------------------

  task automatic stop_run();
    $display("*** FAILED ***");
    $fatal(1, "Run stopped on error");
  endtask

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, actual, expected);
      stop_run();
    end
  endtask

  // Timeout scales with the case count at 6 cycles per symbol plus margin
  initial begin
    wait (cases_loaded);
    #(n_cases * 32 * 6 * 100 + 50000);
    $display("Timeout: the run did not finish in the expected time");
    stop_run();
  end

  //--------------------------------------------------
  // Output monitor
  //--------------------------------------------------

  // Sample mid-cycle where outputs are stable
  always @(negedge clk) begin
    if (bit_vld === 1'b1) begin
      if (pend_q.size() == 0) begin
        $display("Output bit strobe at %0t with no symbol pending", $time);
        stop_run();
      end else begin
        // Strobe cycle minus the cycle the completing symbol was driven
        check(cyc - pend_q.pop_front(), 32'd4, "strobe latency in cycles");
        got_i[n_got] = dout_i;
        got_q[n_got] = dout_q;
        n_got++;
      end
    end
  end

  //--------------------------------------------------
  // Stimulus tasks
  //--------------------------------------------------

  // One APB transfer without wait states
  task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                          input logic [31:0] wdata, input logic exp_err,
                          output logic [31:0] rdata);
    @(posedge clk);
    #DLY;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    // Response stays low until the access phase
    @(negedge clk);
    check(32'(pready), 32'd0, "pready in setup phase");
    check(32'(pslverr), 32'd0, "pslverr in setup phase");
    @(posedge clk);
    #DLY;
    penable = 1'b1;
    @(negedge clk);
    check(32'(pready), 32'd1, "pready in access phase");
    check(32'(pslverr), 32'(exp_err), "pslverr in access phase");
    rdata = prdata;
    @(posedge clk);
    #DLY;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // Random idle gap of 1 to 4 cycles before a one-cycle strobe
  task automatic send_symbol(input logic si, input logic sq, input logic completes);
    int gap;
    gap = 1 + ($urandom % 4);
    repeat (gap) @(posedge clk);
    #DLY;
    symb_en = 1'b1;
    symb_i  = si;
    symb_q  = sq;
    if (completes) begin
      pend_q.push_back(cyc);
    end
    @(posedge clk);
    #DLY;
    symb_en = 1'b0;
  endtask

  task automatic run_case(input int idx);
    logic [7:0]  cfg_byte;
    logic [31:0] nsym;
    logic [31:0] in_i;
    logic [31:0] in_q;
    logic [31:0] exp_i;
    logic [31:0] exp_q;
    logic [31:0] exp_cnt;
    logic [31:0] rdata;
    int          wait_cyc;
    cfg_byte = case_mem[idx*FIELDS][7:0];
    nsym     = case_mem[idx*FIELDS+1];
    in_i     = case_mem[idx*FIELDS+2];
    in_q     = case_mem[idx*FIELDS+3];
    exp_i    = case_mem[idx*FIELDS+4];
    exp_q    = case_mem[idx*FIELDS+5];
    exp_cnt  = case_mem[idx*FIELDS+6];
    // CFG write also clears every stage
    apb_xfer(1'b1, ADDR_W'(REG_CFG), {24'h0, cfg_byte}, 1'b0, rdata);
    n_got = 0;
    got_i = '0;
    got_q = '0;
    apb_xfer(1'b0, ADDR_W'(REG_CFG), 32'h0, 1'b0, rdata);
    check(rdata, {24'h0, cfg_byte}, "CFG readback");
    // Biphase bits complete on odd half-symbols
    for (int k = 0; k < nsym; k++) begin
      send_symbol(in_i[k], in_q[k], !cfg_byte[0] || (k % 2 == 1));
    end
    wait_cyc = 0;
    while (n_got < exp_cnt && wait_cyc < 20) begin
      @(posedge clk);
      wait_cyc++;
    end
    // Extra cycles catch stray strobes
    repeat (3) @(posedge clk);
    check(32'(n_got), exp_cnt, "collected bit count");
    check(got_i, exp_i, "I output word");
    check(got_q, exp_q, "Q output word");
    apb_xfer(1'b0, ADDR_W'(REG_COUNT), 32'h0, 1'b0, rdata);
    check(rdata, exp_cnt, "COUNT register");
  endtask

  //--------------------------------------------------
  // Main sequence
  //--------------------------------------------------

  initial begin
    logic [31:0] rdata;
    void'($urandom(32'h9cf));
    rs      = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = 32'h0;
    symb_en = 1'b0;
    symb_i  = 1'b0;
    symb_q  = 1'b0;
    $readmemh("verification/pcm_decoder_cases.txt", case_mem);
    n_cases = 0;
    while (n_cases < MAX_CASES && !$isunknown(case_mem[n_cases*FIELDS])) begin
      n_cases++;
    end
    if (n_cases == 0) begin
      $display("No test cases were found in the cases file");
      stop_run();
    end
    cases_loaded = 1'b1;
    repeat (16) @(posedge clk);
    #DLY;
    rs = 1'b0;
    // Idle state after reset
    check(32'(bit_vld), 32'd0, "bit_vld_o after reset");
    check(32'(pready), 32'd0, "pready_o after reset");
    check(32'(pslverr), 32'd0, "pslverr_o after reset");
    apb_xfer(1'b0, ADDR_W'(REG_CFG), 32'h0, 1'b0, rdata);
    check(rdata, 32'h0, "CFG after reset");
    // Unmapped offsets must flag an error and leave CFG alone
    apb_xfer(1'b0, ADDR_W'(8), 32'h0, 1'b1, rdata);
    apb_xfer(1'b1, ADDR_W'(12), 32'hff, 1'b1, rdata);
    apb_xfer(1'b0, ADDR_W'(REG_CFG), 32'h0, 1'b0, rdata);
    check(rdata, 32'h0, "CFG after unmapped write");
    for (int c = 0; c < n_cases; c++) begin
      run_case(c);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* verification/pcm_decoder_cases.txt */
// cfg nsym sym_i sym_q exp_i exp_q exp_count, all hex
// Symbol k and output bit k sit in bit k of their words
00 20 A5C30F96 12345678 A5C30F96 12345678 20
02 10 000000F0 00003C5A 00000110 000044EE 10
04 10 000000F0 00003C5A 0000FEEF 0000BB11 10
06 08 0000005A 000000C3 0000005A 000000C3 08
01 10 0000659A 0000A55A 000000B4 0000003C 08
13 10 0000659A 0000A55A 00000023 000000BB 08
20 20 00001234 01000003 00263CB4 21000663 20
40 20 000000FF 80000001 000606FF 80000A01 20
60 20 00000003 00010000 00014003 C0010000 20
C0 20 00000003 00010000 00014003 C0010000 20
80 20 00000005 00008000 000B4005 20008000 20
A0 20 00000021 00000100 10040021 84000100 20
08 08 0000005A 000000C3 000000C3 0000005A 08
10 08 0000005A 000000C3 000000A5 0000003C 08
18 08 0000005A 000000C3 0000003C 000000A5 08

/* list.f */
verilog/pcm_dec_pkg.sv
verilog/pcm_dec_regs.sv
verilog/biphase_to_nrz.sv
verilog/mark_space_decode.sv
verilog/rnrz_derandomizer.sv
verilog/pcm_out_format.sv
verilog/pcm_decoder_top.sv
verification/pcm_decoder_tb.sv
